// File: design/qkv_pkg.sv
/*
  QKV projection engine shared definitions
  Widths, dimension limits, control enums and port structs
*/
`default_nettype none

package qkv_pkg;

  // ----------------------------------------
  // Widths and limits
  // ----------------------------------------
  localparam int DATA_W   = 32;
  localparam int ADDR_W   = 16;
  localparam int DIM_W    = 8;
  localparam int MAX_DIM  = 8;
  localparam int NUM_MATS = 3;
  localparam int MAT_W    = 2;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DIM_W-1:0]  dim_t;
  typedef logic [MAT_W-1:0]  mat_t;

  // Index of the V projection
  localparam mat_t LAST_MAT = mat_t'(NUM_MATS - 1);

  // ----------------------------------------
  // Structs
  // ----------------------------------------
  typedef struct packed {
    dim_t rows;
    dim_t inner;
    dim_t cols;
  } dims_t;

  typedef struct packed {
    dim_t k;
    dim_t col;
    dim_t row;
    mat_t mat;
  } loop_idx_t;

  typedef struct packed {
    logic k_last;
    logic col_last;
    logic row_last;
    logic mat_last;
  } loop_last_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } sram_wr_t;

  // ----------------------------------------
  // Enums
  // ----------------------------------------
  typedef enum logic [1:0] {
    CNT_CLEAR,
    CNT_HOLD,
    CNT_STEP
  } loop_cmd_e;

  typedef enum logic [1:0] {
    MAC_CLEAR,
    MAC_ACC,
    MAC_HOLD
  } mac_op_e;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_DIMS,
    WAIT_DIMS,
    ISSUE,
    DRAIN,
    WRITE,
    DONE
  } fsm_state_e;

endpackage

`default_nettype wire

// File: design/loop_counters.sv
/*
  Nested loop counters over inner, column, row and matrix
*/
`timescale 1ns/1ns
`default_nettype none

module loop_counters (
  input  wire                     clk,
  input  wire                     reset_n,
  input  wire qkv_pkg::loop_cmd_e loop_cmd,
  input  wire qkv_pkg::dims_t     dims,
  output qkv_pkg::loop_idx_t      idx,
  output qkv_pkg::loop_last_t     last
);

  // Final value of each index
  always_comb begin
    last.k_last   = (idx.k   == dims.inner - qkv_pkg::dim_t'(1));
    last.col_last = (idx.col == dims.cols  - qkv_pkg::dim_t'(1));
    last.row_last = (idx.row == dims.rows  - qkv_pkg::dim_t'(1));
    last.mat_last = (idx.mat == qkv_pkg::LAST_MAT);
  end

  // ----------------------------------------
  // Step with carry k -> col -> row -> mat
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      idx <= '0;
    end else begin
      case (loop_cmd)
        qkv_pkg::CNT_CLEAR: idx <= '0;
        qkv_pkg::CNT_STEP: begin
          if (!last.k_last) begin
            idx.k <= idx.k + qkv_pkg::dim_t'(1);
          end else begin
            idx.k <= '0;
            if (!last.col_last) begin
              idx.col <= idx.col + qkv_pkg::dim_t'(1);
            end else begin
              idx.col <= '0;
              if (!last.row_last) begin
                idx.row <= idx.row + qkv_pkg::dim_t'(1);
              end else begin
                idx.row <= '0;
                idx.mat <= last.mat_last ? '0 : idx.mat + 1'b1;
              end
            end
          end
        end
        default: idx <= idx;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/sram_addr_gen.sv
/*
  Dimension capture and SRAM address generation
  Read addresses follow the loop indices, writes use a running pointer
*/
`timescale 1ns/1ns
`default_nettype none

module sram_addr_gen (
  input  wire                         clk,
  input  wire                         reset_n,
  input  wire                         dims_load,
  input  wire                         wr_advance,
  input  wire qkv_pkg::loop_idx_t     idx,
  input  wire  [qkv_pkg::DATA_W-1:0]  input_rd_data,
  input  wire  [qkv_pkg::DATA_W-1:0]  weight_rd_data,
  output qkv_pkg::dims_t              dims,
  output logic [qkv_pkg::ADDR_W-1:0]  input_rd_addr,
  output logic [qkv_pkg::ADDR_W-1:0]  weight_rd_addr,
  output logic [qkv_pkg::ADDR_W-1:0]  result_addr
);

  qkv_pkg::addr_t n_ext;
  qkv_pkg::addr_t k_ext;
  qkv_pkg::addr_t m_ext;
  qkv_pkg::addr_t row_ext;
  qkv_pkg::addr_t col_ext;
  qkv_pkg::addr_t idx_k_ext;
  qkv_pkg::addr_t mat_ext;
  qkv_pkg::addr_t mat_words;
  qkv_pkg::addr_t total_words;
  qkv_pkg::addr_t input_addr_nxt;
  qkv_pkg::addr_t weight_addr_nxt;
  qkv_pkg::addr_t wr_ptr;
  logic           hdr_mode;

  assign n_ext     = qkv_pkg::addr_t'(dims.rows);
  assign k_ext     = qkv_pkg::addr_t'(dims.inner);
  assign m_ext     = qkv_pkg::addr_t'(dims.cols);
  assign row_ext   = qkv_pkg::addr_t'(idx.row);
  assign col_ext   = qkv_pkg::addr_t'(idx.col);
  assign idx_k_ext = qkv_pkg::addr_t'(idx.k);
  assign mat_ext   = qkv_pkg::addr_t'(idx.mat);

  assign mat_words   = k_ext * m_ext;
  assign total_words = qkv_pkg::addr_t'(qkv_pkg::NUM_MATS) * n_ext * m_ext;

  // No job in flight once every result is written, so point at the headers
  assign hdr_mode = (wr_ptr == total_words);

  // I row-major, W column-major per matrix
  assign input_addr_nxt  = qkv_pkg::addr_t'(1) + row_ext * k_ext + idx_k_ext;
  assign weight_addr_nxt = qkv_pkg::addr_t'(1) + mat_ext * mat_words
                         + col_ext * k_ext + idx_k_ext;

  // ----------------------------------------
  // Header capture
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      dims <= '0;
    end else if (dims_load) begin
      dims.rows  <= input_rd_data[16 +: qkv_pkg::DIM_W];
      dims.inner <= input_rd_data[0 +: qkv_pkg::DIM_W];
      dims.cols  <= weight_rd_data[0 +: qkv_pkg::DIM_W];
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      input_rd_addr  <= '0;
      weight_rd_addr <= '0;
    end else if (hdr_mode) begin
      input_rd_addr  <= '0;
      weight_rd_addr <= '0;
    end else begin
      input_rd_addr  <= input_addr_nxt;
      weight_rd_addr <= weight_addr_nxt;
    end
  end

  // Results land in Q, K, V order
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
    end else if (dims_load) begin
      wr_ptr <= '0;
    end else if (wr_advance) begin
      wr_ptr <= wr_ptr + qkv_pkg::addr_t'(1);
    end
  end

  assign result_addr = wr_ptr;

endmodule

`default_nettype wire

// File: design/mac_unit.sv
/*
  Multiply-accumulate with registered result write port
*/
`timescale 1ns/1ns
`default_nettype none

module mac_unit (
  input  wire                         clk,
  input  wire                         reset_n,
  input  wire qkv_pkg::mac_op_e       mac_op,
  input  wire                         wr_req,
  input  wire  [qkv_pkg::DATA_W-1:0]  input_rd_data,
  input  wire  [qkv_pkg::DATA_W-1:0]  weight_rd_data,
  input  wire  [qkv_pkg::ADDR_W-1:0]  result_addr,
  output qkv_pkg::sram_wr_t           result_wr
);

  qkv_pkg::data_t product;
  qkv_pkg::data_t acc;
  qkv_pkg::data_t wr_data;
  qkv_pkg::addr_t wr_addr;
  logic           wr_en;

  // Low 32 bits only
  assign product = input_rd_data * weight_rd_data;

  always_ff @(posedge clk) begin
    case (mac_op)
      qkv_pkg::MAC_CLEAR: acc <= '0;
      qkv_pkg::MAC_ACC:   acc <= acc + product;
      default:            acc <= acc;
    endcase
  end

  // ----------------------------------------
  // Result write port
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= wr_req;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_req) begin
      wr_addr <= result_addr;
      wr_data <= acc;
    end
  end

  assign result_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// File: design/qkv_ctrl_fsm.sv
/*
  QKV engine controller
  Sequences the header load, dot products and result writes
*/
`timescale 1ns/1ns
`default_nettype none

module qkv_ctrl_fsm (
  input  wire                      clk,
  input  wire                      reset_n,
  input  wire                      dut_valid,
  input  wire qkv_pkg::loop_last_t last,
  output logic                     dut_ready,
  output qkv_pkg::loop_cmd_e       loop_cmd,
  output qkv_pkg::mac_op_e         mac_op,
  output logic                     dims_load,
  output logic                     wr_req,
  output logic                     wr_advance
);

  qkv_pkg::fsm_state_e state;
  qkv_pkg::fsm_state_e state_nxt;
  logic [1:0]          issue_pipe;
  logic                all_last;

  assign all_last = last.k_last & last.col_last & last.row_last & last.mat_last;

  // Tracks ISSUE cycles through the address and SRAM stages
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= qkv_pkg::IDLE;
      dut_ready  <= 1'b0;
      issue_pipe <= 2'b00;
    end else begin
      state      <= state_nxt;
      dut_ready  <= (state_nxt == qkv_pkg::IDLE);
      issue_pipe <= {issue_pipe[0], state == qkv_pkg::ISSUE};
    end
  end

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      qkv_pkg::IDLE: begin
        if (dut_valid && dut_ready) begin
          state_nxt = qkv_pkg::LOAD_DIMS;
        end
      end
      qkv_pkg::LOAD_DIMS: state_nxt = qkv_pkg::WAIT_DIMS;
      qkv_pkg::WAIT_DIMS: state_nxt = qkv_pkg::ISSUE;
      qkv_pkg::ISSUE: begin
        if (last.k_last) begin
          state_nxt = qkv_pkg::DRAIN;
        end
      end
      // Wait until the last product has reached the accumulator
      qkv_pkg::DRAIN: begin
        if (!issue_pipe[0]) begin
          state_nxt = qkv_pkg::WRITE;
        end
      end
      qkv_pkg::WRITE: begin
        if (all_last) begin
          state_nxt = qkv_pkg::DONE;
        end else begin
          state_nxt = qkv_pkg::ISSUE;
        end
      end
      qkv_pkg::DONE: state_nxt = qkv_pkg::IDLE;
      default: state_nxt = qkv_pkg::IDLE;
    endcase
  end

  // ----------------------------------------
  // Commands
  // ----------------------------------------
  always_comb begin
    loop_cmd   = qkv_pkg::CNT_HOLD;
    dims_load  = 1'b0;
    wr_req     = 1'b0;
    wr_advance = 1'b0;
    case (state)
      qkv_pkg::IDLE,
      qkv_pkg::LOAD_DIMS: loop_cmd = qkv_pkg::CNT_CLEAR;
      qkv_pkg::WAIT_DIMS: dims_load = 1'b1;
      qkv_pkg::ISSUE: begin
        if (!last.k_last) begin
          loop_cmd = qkv_pkg::CNT_STEP;
        end
      end
      qkv_pkg::WRITE: begin
        loop_cmd   = qkv_pkg::CNT_STEP;
        wr_req     = 1'b1;
        wr_advance = 1'b1;
      end
      default: loop_cmd = qkv_pkg::CNT_HOLD;
    endcase
  end

  // Accumulate as read data arrives, two cycles after issue
  always_comb begin
    if (issue_pipe[1]) begin
      mac_op = qkv_pkg::MAC_ACC;
    end else if (state == qkv_pkg::WRITE || state == qkv_pkg::LOAD_DIMS) begin
      mac_op = qkv_pkg::MAC_CLEAR;
    end else begin
      mac_op = qkv_pkg::MAC_HOLD;
    end
  end

endmodule

`default_nettype wire

// File: design/qkv_engine.sv
/*
  QKV projection engine top level
  Computes Q, K and V from the input and weight SRAMs into the result SRAM
*/
`timescale 1ns/1ns
`default_nettype none

module qkv_engine (
  input  wire                         clk,
  input  wire                         reset_n,
  input  wire                         dut_valid,
  output logic                        dut_ready,
  output logic [qkv_pkg::ADDR_W-1:0]  input_rd_addr,
  input  wire  [qkv_pkg::DATA_W-1:0]  input_rd_data,
  output logic [qkv_pkg::ADDR_W-1:0]  weight_rd_addr,
  input  wire  [qkv_pkg::DATA_W-1:0]  weight_rd_data,
  output qkv_pkg::sram_wr_t           result_wr
);

  qkv_pkg::loop_cmd_e  loop_cmd;
  qkv_pkg::mac_op_e    mac_op;
  qkv_pkg::loop_idx_t  idx;
  qkv_pkg::loop_last_t last;
  qkv_pkg::dims_t      dims;
  qkv_pkg::addr_t      result_addr;
  logic                dims_load;
  logic                wr_req;
  logic                wr_advance;

  // ----------------------------------------
  // Control
  // ----------------------------------------
  qkv_ctrl_fsm u_ctrl (
    .clk        (clk),
    .reset_n    (reset_n),
    .dut_valid  (dut_valid),
    .last       (last),
    .dut_ready  (dut_ready),
    .loop_cmd   (loop_cmd),
    .mac_op     (mac_op),
    .dims_load  (dims_load),
    .wr_req     (wr_req),
    .wr_advance (wr_advance)
  );

  loop_counters u_counters (
    .clk      (clk),
    .reset_n  (reset_n),
    .loop_cmd (loop_cmd),
    .dims     (dims),
    .idx      (idx),
    .last     (last)
  );

  // ----------------------------------------
  // Data path
  // ----------------------------------------
  sram_addr_gen u_addr_gen (
    .clk            (clk),
    .reset_n        (reset_n),
    .dims_load      (dims_load),
    .wr_advance     (wr_advance),
    .idx            (idx),
    .input_rd_data  (input_rd_data),
    .weight_rd_data (weight_rd_data),
    .dims           (dims),
    .input_rd_addr  (input_rd_addr),
    .weight_rd_addr (weight_rd_addr),
    .result_addr    (result_addr)
  );

  mac_unit u_mac (
    .clk            (clk),
    .reset_n        (reset_n),
    .mac_op         (mac_op),
    .wr_req         (wr_req),
    .input_rd_data  (input_rd_data),
    .weight_rd_data (weight_rd_data),
    .result_addr    (result_addr),
    .result_wr      (result_wr)
  );

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
/*
  Testbench clock and reset generator
  20 ns clock, reset held low for 16 cycles
*/
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Release just after an edge, like the other stimulus
  initial begin
    reset_n = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    reset_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/tb_sram.sv
/*
  SRAM model with one-cycle read latency and a write port
*/
`timescale 1ns/1ns
`default_nettype none

module tb_sram (
  input  wire                         clk,
  input  wire  [qkv_pkg::ADDR_W-1:0]  rd_addr,
  output logic [qkv_pkg::DATA_W-1:0]  rd_data,
  input  wire qkv_pkg::sram_wr_t      wr
);

  // Full address space, loaded directly by the testbench
  logic [qkv_pkg::DATA_W-1:0] mem [0:(1 << qkv_pkg::ADDR_W) - 1];

  initial begin
    rd_data = '0;
  end

  always @(posedge clk) begin
    rd_data <= mem[rd_addr];
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

endmodule

`default_nettype wire

// File: verification/qkv_props.sv
/*
  Handshake and result write properties of the QKV engine
*/
`timescale 1ns/1ns
`default_nettype none

module qkv_props (
  input wire                      clk,
  input wire                      reset_n,
  input wire                      dut_valid,
  input wire                      dut_ready,
  input wire qkv_pkg::fsm_state_e state,
  input wire                      wr_en
);

  // Failed property evaluations so far
  int fail_count = 0;

  idle_no_write: assert property (
    @(posedge clk) disable iff (!reset_n)
    (state == qkv_pkg::IDLE) |-> !wr_en
  ) else begin
    fail_count++;
    $error("result write enable high while the controller is idle");
  end

  // Accepted start drops ready within two cycles
  ready_drops: assert property (
    @(posedge clk) disable iff (!reset_n)
    (dut_valid && dut_ready) |-> ##[1:2] !dut_ready
  ) else begin
    fail_count++;
    $error("dut_ready still high two cycles after an accepted start");
  end

  write_pulse: assert property (
    @(posedge clk) disable iff (!reset_n)
    wr_en |=> !wr_en
  ) else begin
    fail_count++;
    $error("result write enable high for more than one cycle");
  end

endmodule

bind qkv_engine qkv_props u_props (
  .clk       (clk),
  .reset_n   (reset_n),
  .dut_valid (dut_valid),
  .dut_ready (dut_ready),
  .state     (u_ctrl.state),
  .wr_en     (result_wr.en)
);

`default_nettype wire

// File: verification/qkv_tb.sv
/*
  Testbench for the QKV projection engine
  Random jobs checked against a reference model of the three projections
*/
`timescale 1ns/1ns
`default_nettype none

module qkv_tb;

  logic                        clk;
  logic                        reset_n;
  logic                        dut_valid;
  logic                        dut_ready;
  logic [qkv_pkg::ADDR_W-1:0]  input_rd_addr;
  logic [qkv_pkg::ADDR_W-1:0]  weight_rd_addr;
  logic [qkv_pkg::DATA_W-1:0]  input_rd_data;
  logic [qkv_pkg::DATA_W-1:0]  weight_rd_data;
  qkv_pkg::sram_wr_t           result_wr;
  qkv_pkg::sram_wr_t           no_wr;

  integer seed = 17;
  int     num_jobs = 8;
  int     error_count = 0;
  int     check_count = 0;
  int     write_count = 0;
  int     n_dim = 0;
  int     k_dim = 0;
  int     m_dim = 0;
  int     job = 0;

  // Model copies of I and of the three weight matrices as w_mat[w][k][j]
  logic [qkv_pkg::DATA_W-1:0] a_mat [qkv_pkg::MAX_DIM][qkv_pkg::MAX_DIM];
  logic [qkv_pkg::DATA_W-1:0] w_mat [qkv_pkg::NUM_MATS][qkv_pkg::MAX_DIM][qkv_pkg::MAX_DIM];

  assign no_wr = '0;

  tb_clock u_clock (.clk(clk), .reset_n(reset_n));

  tb_sram u_input_mem (
    .clk(clk), .rd_addr(input_rd_addr), .rd_data(input_rd_data), .wr(no_wr)
  );
  tb_sram u_weight_mem (
    .clk(clk), .rd_addr(weight_rd_addr), .rd_data(weight_rd_data), .wr(no_wr)
  );
  tb_sram u_result_mem (
    .clk(clk), .rd_addr(qkv_pkg::addr_t'(0)), .rd_data(), .wr(result_wr)
  );

  qkv_engine DUT (
    .clk            (clk),
    .reset_n        (reset_n),
    .dut_valid      (dut_valid),
    .dut_ready      (dut_ready),
    .input_rd_addr  (input_rd_addr),
    .input_rd_data  (input_rd_data),
    .weight_rd_addr (weight_rd_addr),
    .weight_rd_data (weight_rd_data),
    .result_wr      (result_wr)
  );

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  function automatic int rand_dim();
    return 1 + ($unsigned($random(seed)) % qkv_pkg::MAX_DIM);
  endfunction

  function automatic string proj_name(input int w);
    if (w == 0) return "Q";
    else if (w == 1) return "K";
    return "V";
  endfunction

  // ----------------------------------------
  // Job setup and handshake
  // ----------------------------------------
  task automatic load_job(input int job_idx);
    if (job_idx == 0) begin
      n_dim = 1;
      k_dim = 1;
      m_dim = 1;
    end else if (job_idx == 1) begin
      n_dim = qkv_pkg::MAX_DIM;
      k_dim = qkv_pkg::MAX_DIM;
      m_dim = qkv_pkg::MAX_DIM;
    end else begin
      n_dim = rand_dim();
      k_dim = rand_dim();
      m_dim = rand_dim();
    end
    u_input_mem.mem[0]  = {16'(n_dim), 16'(k_dim)};
    u_weight_mem.mem[0] = {16'(k_dim), 16'(m_dim)};
    for (int i = 0; i < n_dim; i++) begin
      for (int kk = 0; kk < k_dim; kk++) begin
        a_mat[i][kk] = $random(seed);
        u_input_mem.mem[1 + i * k_dim + kk] = a_mat[i][kk];
      end
    end
    for (int w = 0; w < qkv_pkg::NUM_MATS; w++) begin
      for (int j = 0; j < m_dim; j++) begin
        for (int kk = 0; kk < k_dim; kk++) begin
          w_mat[w][kk][j] = $random(seed);
          u_weight_mem.mem[1 + w * k_dim * m_dim + j * k_dim + kk] = w_mat[w][kk][j];
        end
      end
    end
    // Stale words show up as mismatches if a write goes missing
    for (int a = 0; a < qkv_pkg::NUM_MATS * qkv_pkg::MAX_DIM * qkv_pkg::MAX_DIM; a++) begin
      u_result_mem.mem[a] = {16'hbad0, 16'(a)};
    end
    write_count = 0;
  endtask

  task automatic run_job();
    while (!dut_ready) step();
    dut_valid = 1'b1;
    step();
    dut_valid = 1'b0;
    if (dut_ready) step();
    check_count++;
    assert (!dut_ready) else begin
      error_count++;
      $display("job %0d: dut_ready did not fall after the start was accepted", job);
    end
    while (!dut_ready) step();
  endtask

  task automatic check_results(input int job_idx);
    logic [qkv_pkg::DATA_W-1:0] expected;
    logic [qkv_pkg::DATA_W-1:0] actual;
    int                         addr;
    string                      name;
    for (int w = 0; w < qkv_pkg::NUM_MATS; w++) begin
      for (int i = 0; i < n_dim; i++) begin
        for (int j = 0; j < m_dim; j++) begin
          expected = '0;
          for (int kk = 0; kk < k_dim; kk++) begin
            expected = expected + a_mat[i][kk] * w_mat[w][kk][j];
          end
          addr   = w * n_dim * m_dim + i * m_dim + j;
          actual = u_result_mem.mem[addr];
          name   = $sformatf("job %0d %s[%0d][%0d]", job_idx, proj_name(w), i, j);
          check_count++;
          assert (actual === expected) else begin
            error_count++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
          end
        end
      end
    end
    check_count++;
    assert (write_count == qkv_pkg::NUM_MATS * n_dim * m_dim) else begin
      error_count++;
      $display("mismatch job %0d write count: expected %0d, actual %0d",
               job_idx, qkv_pkg::NUM_MATS * n_dim * m_dim, write_count);
    end
  endtask

  // Write port monitor sampled mid-cycle
  always @(negedge clk) begin
    if (reset_n === 1'b1 && result_wr.en === 1'b1) begin
      write_count++;
      check_count += 2;
      assert (int'(result_wr.addr) < qkv_pkg::NUM_MATS * n_dim * m_dim) else begin
        error_count++;
        $display("job %0d: result write to address %0d lies outside the result area",
                 job, result_wr.addr);
      end
      assert (!dut_ready) else begin
        error_count++;
        $display("job %0d: result write while dut_ready is high", job);
      end
    end
  end

  // ----------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------
  initial begin : main_sequence
    dut_valid = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    check_count++;
    assert (!dut_ready && !result_wr.en) else begin
      error_count++;
      $display("dut_ready or result write enable high during reset");
    end
    wait (reset_n === 1'b1);
    step();
    check_count++;
    assert (dut_ready) else begin
      error_count++;
      $display("dut_ready did not rise one cycle after reset release");
    end
    for (job = 0; job < num_jobs; job++) begin
      load_job(job);
      run_job();
      check_results(job);
    end
    $display("errors: %0d in %0d checks, %0d property failures over %0d jobs",
             error_count, check_count, DUT.u_props.fail_count, num_jobs);
    if (error_count == 0 && DUT.u_props.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (num_jobs * 3 * qkv_pkg::MAX_DIM ** 3 * 4 + 2000) @(posedge clk);
    $display("timeout: job %0d did not finish within the cycle limit", job);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: qkv_engine.f
design/qkv_pkg.sv
design/loop_counters.sv
design/sram_addr_gen.sv
design/mac_unit.sv
design/qkv_ctrl_fsm.sv
design/qkv_engine.sv
verification/tb_clock.sv
verification/tb_sram.sv
verification/qkv_props.sv
verification/qkv_tb.sv

// File: Bender.yml
package:
  name: qkv_engine

sources:
  # RTL, package first
  - design/qkv_pkg.sv
  - design/loop_counters.sv
  - design/sram_addr_gen.sv
  - design/mac_unit.sv
  - design/qkv_ctrl_fsm.sv
  - design/qkv_engine.sv

  # Testbench
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/tb_sram.sv
      - verification/qkv_props.sv
      - verification/qkv_tb.sv
